/* source/exec_params.svh */
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Datapath widths
`define XLEN         32
`define PREG_IDX_W   6
`define BMASK_W      4

// Functional unit counts
`define NUM_FU_ALU   2
`define NUM_FU_MULT  1
`define NUM_FU_TOTAL 3

// Completion bus width and multiplier depth
`define CDB_WIDTH    2
`define MULT_STAGES  4

`endif

/* source/exec_pkg.sv */
`include "exec_params.svh"

package exec_pkg;

    // Shifts take the low 5 bits of rs2
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU
    } alu_func_e;

    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } branch_func_e;

    typedef struct packed {
        logic                   valid;
        alu_func_e              func;
        logic [`XLEN-1:0]       rs1_value;
        logic [`XLEN-1:0]       rs2_value;
        logic [`PREG_IDX_W-1:0] dest_reg;
        logic [`BMASK_W-1:0]    b_mask;
    } alu_packet_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       rs1_value;
        logic [`XLEN-1:0]       rs2_value;
        logic [`PREG_IDX_W-1:0] dest_reg;
        logic [`BMASK_W-1:0]    b_mask;
    } mult_packet_t;

    // b_mask_bit is the branch's own one-hot bit
    typedef struct packed {
        logic                valid;
        branch_func_e        func;
        logic [`XLEN-1:0]    rs1_value;
        logic [`XLEN-1:0]    rs2_value;
        logic [`XLEN-1:0]    pc;
        logic [`XLEN-1:0]    offset;
        logic                predicted_taken;
        logic [`XLEN-1:0]    predicted_target;
        logic [`BMASK_W-1:0] b_mask_bit;
    } branch_packet_t;

    typedef struct packed {
        logic                   valid;
        logic [`PREG_IDX_W-1:0] dest_reg;
        logic [`XLEN-1:0]       result;
    } cdb_packet_t;

    typedef struct packed {
        logic                valid;
        logic                taken;
        logic [`XLEN-1:0]    target;
        logic                mispredict;
        logic [`BMASK_W-1:0] b_mask_bit;
    } branch_resolve_t;

endpackage

/* source/alu.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module alu
    import exec_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  alu_packet_t         issue,
    output logic                ready,
    input  logic [`BMASK_W-1:0] b_mm_resolve,
    input  logic                b_mm_mispred,
    input  logic                grant,
    output cdb_packet_t         result
);

    alu_packet_t      held;
    alu_packet_t      held_next;
    logic             killed;
    logic [`XLEN-1:0] value;

    // Held op depends on the branch mispredicting right now
    assign killed = b_mm_mispred && |(held.b_mask & b_mm_resolve);

    assign result = '{valid: held.valid && !killed, dest_reg: held.dest_reg, result: value};

    // Slot frees up when empty, killed or leaving on the CDB
    assign ready = !result.valid || grant;

    always_comb begin
        held_next = held;
        if (grant) begin
            held_next.valid = 1'b0;
        end
        if (issue.valid && ready) begin
            held_next = issue;
        end
        // Squash applies to the stored op and to a new arrival alike
        if (b_mm_mispred && |(held_next.b_mask & b_mm_resolve)) begin
            held_next.valid = 1'b0;
        end
        held_next.b_mask = held_next.b_mask & ~b_mm_resolve;
    end

    always_comb begin
        case (held.func)
            ADD:     value = held.rs1_value + held.rs2_value;
            SUB:     value = held.rs1_value - held.rs2_value;
            AND:     value = held.rs1_value & held.rs2_value;
            OR:      value = held.rs1_value | held.rs2_value;
            XOR:     value = held.rs1_value ^ held.rs2_value;
            SLL:     value = held.rs1_value << held.rs2_value[4:0];
            SRL:     value = held.rs1_value >> held.rs2_value[4:0];
            SRA:     value = $signed(held.rs1_value) >>> held.rs2_value[4:0];
            SLT:     value = {{(`XLEN-1){1'b0}}, $signed(held.rs1_value) < $signed(held.rs2_value)};
            SLTU:    value = {{(`XLEN-1){1'b0}}, held.rs1_value < held.rs2_value};
            default: value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            held.valid <= 1'b0;
        end else begin
            held <= held_next;
        end
    end

endmodule

/* source/mult.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module mult
    import exec_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  mult_packet_t        issue,
    output logic                free,
    input  logic [`BMASK_W-1:0] b_mm_resolve,
    input  logic                b_mm_mispred,
    input  logic                grant,
    output cdb_packet_t         result
);

    // Multiplier bits folded in per stage
    localparam int CHUNK = `XLEN / `MULT_STAGES;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       a;
        logic [`XLEN-1:0]       b;
        logic [`XLEN-1:0]       prod;
        logic [`PREG_IDX_W-1:0] dest_reg;
        logic [`BMASK_W-1:0]    b_mask;
    } stage_t;

    stage_t stage      [`MULT_STAGES];
    stage_t stage_next [`MULT_STAGES];
    logic   killed;
    logic   stall;

    // Adds rs1 times chunk k of rs2, keeping the low XLEN bits
    function automatic stage_t add_chunk(input stage_t s, input int k);
        stage_t o;
        o = s;
        o.prod = s.prod + ((s.a * `XLEN'(s.b[k*CHUNK +: CHUNK])) << (k*CHUNK));
        return o;
    endfunction

    assign killed = b_mm_mispred &&
                    |(stage[`MULT_STAGES-1].b_mask & b_mm_resolve);

    assign result = '{valid:    stage[`MULT_STAGES-1].valid && !killed,
                      dest_reg: stage[`MULT_STAGES-1].dest_reg,
                      result:   stage[`MULT_STAGES-1].prod};

    // Whole pipe holds while the finished product waits for the CDB
    assign stall = result.valid && !grant;
    assign free  = !stall;

    always_comb begin
        stage_t entry;
        entry.valid    = issue.valid;
        entry.a        = issue.rs1_value;
        entry.b        = issue.rs2_value;
        entry.prod     = '0;
        entry.dest_reg = issue.dest_reg;
        entry.b_mask   = issue.b_mask;

        if (stall) begin
            stage_next[0] = stage[0];
        end else begin
            stage_next[0] = add_chunk(entry, 0);
        end
        for (int k = 1; k < `MULT_STAGES; k++) begin
            if (stall) begin
                stage_next[k] = stage[k];
            end else begin
                stage_next[k] = add_chunk(stage[k-1], k);
            end
        end

        // Branch resolution reaches every stage, stalled or not
        for (int k = 0; k < `MULT_STAGES; k++) begin
            if (b_mm_mispred && |(stage_next[k].b_mask & b_mm_resolve)) begin
                stage_next[k].valid = 1'b0;
            end
            stage_next[k].b_mask = stage_next[k].b_mask & ~b_mm_resolve;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < `MULT_STAGES; k++) begin
                stage[k].valid <= 1'b0;
            end
        end else begin
            stage <= stage_next;
        end
    end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module branch_unit
    import exec_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  branch_packet_t  issue,
    output branch_resolve_t resolve
);

    branch_resolve_t  resolve_next;
    logic             taken;
    logic             mispredict;
    logic [`XLEN-1:0] target;

    always_comb begin
        case (issue.func)
            BEQ:     taken = issue.rs1_value == issue.rs2_value;
            BNE:     taken = issue.rs1_value != issue.rs2_value;
            BLT:     taken = $signed(issue.rs1_value) < $signed(issue.rs2_value);
            BGE:     taken = $signed(issue.rs1_value) >= $signed(issue.rs2_value);
            BLTU:    taken = issue.rs1_value < issue.rs2_value;
            BGEU:    taken = issue.rs1_value >= issue.rs2_value;
            default: taken = 1'b0;
        endcase
    end

    // Fall-through is the next sequential instruction
    assign target = taken ? issue.pc + issue.offset : issue.pc + `XLEN'(4);

    // Wrong direction, or taken to the wrong place
    assign mispredict = issue.valid &&
                        ((taken != issue.predicted_taken) ||
                         (taken && (target != issue.predicted_target)));

    assign resolve_next = '{valid:      issue.valid,
                            taken:      taken,
                            target:     target,
                            mispredict: mispredict,
                            b_mask_bit: issue.b_mask_bit};

    always_ff @(posedge clock) begin
        if (reset) begin
            resolve.valid <= 1'b0;
        end else begin
            resolve <= resolve_next;
        end
    end

endmodule

/* source/completion_arbiter.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module completion_arbiter
    import exec_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  cdb_packet_t [`NUM_FU_TOTAL-1:0]     fu_results,
    output logic        [`NUM_FU_TOTAL-1:0]     grants,
    output cdb_packet_t [`CDB_WIDTH-1:0]        cdb
);

    cdb_packet_t [`CDB_WIDTH-1:0] cdb_next;

    // Index 0 has highest priority; valid sources fill CDB slots in order
    always_comb begin
        int slot;
        slot     = 0;
        grants   = '0;
        cdb_next = '0;
        for (int j = 0; j < `NUM_FU_TOTAL; j++) begin
            if (fu_results[j].valid && (slot < `CDB_WIDTH)) begin
                grants[j]      = 1'b1;
                cdb_next[slot] = fu_results[j];
                slot++;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `CDB_WIDTH; i++) begin
                cdb[i].valid <= 1'b0;
            end
        end else begin
            cdb <= cdb_next;
        end
    end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module execute_stage
    import exec_pkg::*;
(
    input  logic                               clock,
    input  logic                               reset,
    input  alu_packet_t [`NUM_FU_ALU-1:0]      alu_issue,
    output logic        [`NUM_FU_ALU-1:0]      alu_ready,
    input  mult_packet_t                       mult_issue,
    output logic                               mult_free,
    input  branch_packet_t                     branch_issue,
    input  logic        [`BMASK_W-1:0]         b_mm_resolve,
    input  logic                               b_mm_mispred,
    output cdb_packet_t [`CDB_WIDTH-1:0]       cdb,
    output branch_resolve_t                    branch_resolve
);

    // Multiplier sits at index 0 so it wins arbitration, ALUs follow
    cdb_packet_t [`NUM_FU_TOTAL-1:0] fu_results;
    logic        [`NUM_FU_TOTAL-1:0] grants;

    mult u_mult (
        .clock        (clock),
        .reset        (reset),
        .issue        (mult_issue),
        .free         (mult_free),
        .b_mm_resolve (b_mm_resolve),
        .b_mm_mispred (b_mm_mispred),
        .grant        (grants[0]),
        .result       (fu_results[0])
    );

    for (genvar i = 0; i < `NUM_FU_ALU; i++) begin : g_alu
        alu u_alu (
            .clock        (clock),
            .reset        (reset),
            .issue        (alu_issue[i]),
            .ready        (alu_ready[i]),
            .b_mm_resolve (b_mm_resolve),
            .b_mm_mispred (b_mm_mispred),
            .grant        (grants[`NUM_FU_MULT+i]),
            .result       (fu_results[`NUM_FU_MULT+i])
        );
    end

    branch_unit u_branch (
        .clock   (clock),
        .reset   (reset),
        .issue   (branch_issue),
        .resolve (branch_resolve)
    );

    completion_arbiter u_arbiter (
        .clock      (clock),
        .reset      (reset),
        .fu_results (fu_results),
        .grants     (grants),
        .cdb        (cdb)
    );

endmodule

/* dv/execute_assert.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module execute_assert
    import exec_pkg::*;
(
    input logic                         clock,
    input logic                         reset,
    input cdb_packet_t [`CDB_WIDTH-1:0] cdb,
    input logic                         mult_free,
    input cdb_packet_t                  mult_result
);

    // One tag written twice in a cycle
    cdb_unique_tag: assert property (@(posedge clock) disable iff (reset)
        (cdb[0].valid && cdb[1].valid) |-> (cdb[0].dest_reg != cdb[1].dest_reg))
        else $error("both CDB slots carry tag %0d", cdb[0].dest_reg);

    cdb_idle_after_reset: assert property (@(posedge clock)
        reset |=> !(cdb[0].valid || cdb[1].valid))
        else $error("CDB valid in the cycle after reset");

    // A product held back by the CDB stays in the last stage
    mult_stall_holds: assert property (@(posedge clock) disable iff (reset)
        !mult_free |=> $stable({mult_result.dest_reg, mult_result.result}))
        else $error("multiplier result changed while stalled");

endmodule

/* dv/execute_tb.sv */
`timescale 1ns/10ps
`include "exec_params.svh"

module execute_tb
    import exec_pkg::*;
();

    localparam int ISSUE_CYCLES   = 2000;
    localparam int TIMEOUT_CYCLES = ISSUE_CYCLES + 200;
    localparam int NUM_TAGS       = 1 << `PREG_IDX_W;
    localparam logic [`XLEN-1:0] SIGN_BIT = {1'b1, {(`XLEN-1){1'b0}}};

    logic                            clock;
    logic                            reset;
    alu_packet_t  [`NUM_FU_ALU-1:0]  alu_issue;
    logic         [`NUM_FU_ALU-1:0]  alu_ready;
    mult_packet_t                    mult_issue;
    logic                            mult_free;
    branch_packet_t                  branch_issue;
    logic         [`BMASK_W-1:0]     b_mm_resolve;
    logic                            b_mm_mispred;
    cdb_packet_t  [`CDB_WIDTH-1:0]   cdb;
    branch_resolve_t                 branch_resolve;

    // Scoreboard indexed by tag, plus packets waiting for ready
    logic [19:0]         lfsr;
    int                  free_tags[$];
    logic                pending   [NUM_TAGS];
    logic [`XLEN-1:0]    exp_value [NUM_TAGS];
    logic [`BMASK_W-1:0] exp_mask  [NUM_TAGS];
    alu_packet_t         alu_next  [`NUM_FU_ALU];
    mult_packet_t        mult_next;
    branch_resolve_t     exp_branch;
    logic                issuing;
    int                  cycles;

    execute_stage DUT (.*);

    bind execute_stage execute_assert u_assert (
        .clock       (clock),
        .reset       (reset),
        .cdb         (cdb),
        .mult_free   (mult_free),
        .mult_result (fu_results[0])
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        if (!reset) begin
            cycles <= cycles + 1;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout after %0d cycles, %0d tags never completed",
                         cycles, NUM_TAGS - free_tags.size());
                $display("TEST FAIL");
                $fatal(1, "run did not finish in time");
            end
        end
    end

    // Fibonacci LFSR x^20 + x^17 + 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[19] ^ lfsr[16];
            lfsr = {lfsr[18:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [`XLEN-1:0] alu_model(input alu_func_e f,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        logic [4:0]       sh;
        logic [`XLEN-1:0] fill;
        sh   = b[4:0];
        fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0;
        case (f)
            ADD:     return a + b;
            SUB:     return a + ~b + 1;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << sh;
            SRL:     return a >> sh;
            SRA:     return (a >> sh) | fill;
            // Flipping the sign bit turns a signed compare into an unsigned one
            SLT:     return `XLEN'((a ^ SIGN_BIT) < (b ^ SIGN_BIT));
            SLTU:    return `XLEN'(a < b);
            default: return '0;
        endcase
    endfunction

    function automatic branch_resolve_t branch_model(input branch_packet_t p);
        branch_resolve_t r;
        logic            lt_s;
        logic            lt_u;
        logic            t;
        lt_s = (p.rs1_value ^ SIGN_BIT) < (p.rs2_value ^ SIGN_BIT);
        lt_u = p.rs1_value < p.rs2_value;
        case (p.func)
            BEQ:     t = p.rs1_value == p.rs2_value;
            BNE:     t = p.rs1_value != p.rs2_value;
            BLT:     t = lt_s;
            BGE:     t = !lt_s;
            BLTU:    t = lt_u;
            BGEU:    t = !lt_u;
            default: t = 1'b0;
        endcase
        r.valid      = p.valid;
        r.taken      = t;
        r.target     = t ? p.pc + p.offset : p.pc + 4;
        r.mispredict = p.valid && (t != p.predicted_taken ||
                                   (t && r.target != p.predicted_target));
        r.b_mask_bit = p.b_mask_bit;
        return r;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic compare_cdb(input cdb_packet_t got, input cdb_packet_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("cdb tag %0d result %h, expected outstanding %b result %h",
                                      got.dest_reg, got.result, exp.valid, exp.result));
        end
    endtask

    task automatic compare_branch(input branch_resolve_t got, input branch_resolve_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            report_mismatch($sformatf("branch resolve %h, expected %h", got, exp));
        end
    endtask

    // Mispredict kills dependents, a correct resolution clears the bit
    task automatic apply_squash();
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (pending[t] && b_mm_mispred && |(exp_mask[t] & b_mm_resolve)) begin
                pending[t] = 1'b0;
                free_tags.push_back(t);
            end else if (pending[t]) begin
                exp_mask[t] &= ~b_mm_resolve;
            end
        end
    endtask

    task automatic settle_issue(input logic accepted, input logic [`PREG_IDX_W-1:0] tag,
                                input logic [`XLEN-1:0] value, inout logic valid,
                                inout logic [`BMASK_W-1:0] mask);
        if (accepted) begin
            pending[tag]   = 1'b1;
            exp_value[tag] = value;
            exp_mask[tag]  = mask;
            valid          = 1'b0;
        end else if (b_mm_mispred && |(mask & b_mm_resolve)) begin
            free_tags.push_back(tag);
            valid = 1'b0;
        end else begin
            mask &= ~b_mm_resolve;
        end
    endtask

    task automatic drive_inputs();
        branch_packet_t bp;
        bp = '0;
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            if (issuing && !alu_next[i].valid && free_tags.size() > 0 && take_bits(2) != 0) begin
                alu_next[i].valid     = 1'b1;
                alu_next[i].func      = alu_func_e'(4'(take_bits(4) % 10));
                alu_next[i].rs1_value = take_bits(32);
                alu_next[i].rs2_value = take_bits(32);
                alu_next[i].dest_reg  = `PREG_IDX_W'(free_tags.pop_front());
                alu_next[i].b_mask    = `BMASK_W'(take_bits(4) & take_bits(4));
            end
            alu_issue[i] <= alu_next[i];
        end
        if (issuing && !mult_next.valid && free_tags.size() > 0 && take_bits(2) != 0) begin
            mult_next.valid     = 1'b1;
            mult_next.rs1_value = take_bits(32);
            mult_next.rs2_value = take_bits(32);
            mult_next.dest_reg  = `PREG_IDX_W'(free_tags.pop_front());
            mult_next.b_mask    = `BMASK_W'(take_bits(4) & take_bits(4));
        end
        mult_issue <= mult_next;
        if (issuing && take_bits(1)) begin
            bp.valid            = 1'b1;
            bp.func             = branch_func_e'(3'(take_bits(3) % 6));
            bp.rs1_value        = take_bits(32);
            bp.rs2_value        = take_bits(1) ? bp.rs1_value : take_bits(32);
            bp.pc               = take_bits(32);
            bp.offset           = take_bits(12);
            bp.predicted_taken  = take_bits(1);
            bp.predicted_target = take_bits(1) ? bp.pc + bp.offset : take_bits(32);
            bp.b_mask_bit       = 4'b0001 << take_bits(2);
        end
        branch_issue <= bp;
        if (issuing && take_bits(3) == 0) begin
            b_mm_resolve <= 4'b0001 << take_bits(2);
            b_mm_mispred <= take_bits(1);
        end else begin
            b_mm_resolve <= '0;
            b_mm_mispred <= 1'b0;
        end
    endtask

    // Checks the edge just passed, then models the coming edge
    task automatic sample_outputs();
        cdb_packet_t exp;
        for (int s = 0; s < `CDB_WIDTH; s++) begin
            if (cdb[s].valid) begin
                exp = '{valid: pending[cdb[s].dest_reg], dest_reg: cdb[s].dest_reg,
                        result: exp_value[cdb[s].dest_reg]};
                compare_cdb(cdb[s], exp);
                pending[cdb[s].dest_reg] = 1'b0;
                free_tags.push_back(cdb[s].dest_reg);
            end
        end
        compare_branch(branch_resolve, exp_branch);
        exp_branch = branch_model(branch_issue);
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            if (alu_next[i].valid) begin
                settle_issue(alu_ready[i], alu_next[i].dest_reg,
                             alu_model(alu_next[i].func, alu_next[i].rs1_value,
                                       alu_next[i].rs2_value),
                             alu_next[i].valid, alu_next[i].b_mask);
            end
        end
        if (mult_next.valid) begin
            settle_issue(mult_free, mult_next.dest_reg,
                         mult_next.rs1_value * mult_next.rs2_value,
                         mult_next.valid, mult_next.b_mask);
        end
        apply_squash();
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        alu_issue    = '0;
        mult_issue   = '0;
        branch_issue = '0;
        b_mm_resolve = '0;
        b_mm_mispred = 1'b0;
        lfsr         = 20'd78082;
        cycles       = 0;
        issuing      = 1'b0;
        exp_branch   = '0;
        mult_next    = '0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t] = 1'b0;
            free_tags.push_back(t);
        end
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            alu_next[i] = '0;
        end
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if ({cdb[1].valid, cdb[0].valid, branch_resolve.valid} !== 3'b000 ||
            alu_ready !== '1 || mult_free !== 1'b1) begin
            report_mismatch("outputs not idle right after reset");
        end
        issuing = 1'b1;
        for (int n = 0; n < ISSUE_CYCLES; n++) begin
            @(posedge clock);
            drive_inputs();
            @(negedge clock);
            sample_outputs();
        end
        issuing = 1'b0;
        // Every tag back on the free list means nothing was lost
        while (free_tags.size() != NUM_TAGS) begin
            @(posedge clock);
            drive_inputs();
            @(negedge clock);
            sample_outputs();
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+source
source/exec_pkg.sv
source/alu.sv
source/mult.sv
source/branch_unit.sv
source/completion_arbiter.sv
source/execute_stage.sv
dv/execute_assert.sv
dv/execute_tb.sv

/* Bender.yml */
package:
  name: execute_stage

sources:
  - include_dirs:
      - source
    files:
      - source/exec_pkg.sv
      - source/alu.sv
      - source/mult.sv
      - source/branch_unit.sv
      - source/completion_arbiter.sv
      - source/execute_stage.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/execute_assert.sv
      - dv/execute_tb.sv
